// ==== all.f ====
+incdir+include
hdl/rob_pkg.sv
hdl/dispatch_stage.sv
hdl/wb_hold_stage.sv
hdl/reorder_buffer.sv
hdl/commit_stage.sv
hdl/rob_top.sv
testbench/tb_rob_top.sv

// ==== hdl/commit_stage.sv ====
/* registers the retiring entries; a retiring exception restarts at the exception
   vector, a redirect at its branch target, and flush pulses with that commit */
`timescale 1ns/1ps
`include "rob_config.svh"

module commit_stage
  import rob_pkg::*;
(
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic [`COMMIT_WIDTH-1:0]              cmt_valid,
  input  rob_entry_t [`COMMIT_WIDTH-1:0]        cmt_entry,
  output logic [`COMMIT_WIDTH-1:0]              commit_valid,
  output logic [`COMMIT_WIDTH-1:0][`PC_W-1:0]   commit_pc,
  output logic [`COMMIT_WIDTH-1:0][`AREG_W-1:0] commit_dest,
  output logic                                  redirect,
  output logic [`PC_W-1:0]                      redirect_pc,
  output logic                                  flush
);

  logic             redirect_n;
  logic [`PC_W-1:0] target_n;

  // masking lets at most one retiring entry carry a redirect or exception
  always_comb begin
    redirect_n = 1'b0;
    target_n   = '0;
    for (int i = 0; i < `COMMIT_WIDTH; i++) begin
      if (cmt_valid[i] && (cmt_entry[i].exc || cmt_entry[i].br_redirect)) begin
        redirect_n = 1'b1;
        // exception wins over a branch target
        target_n   = cmt_entry[i].exc ? `EXC_VECTOR : cmt_entry[i].br_target;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      commit_valid <= '0;
      redirect     <= 1'b0;
    end else begin
      commit_valid <= cmt_valid;
      redirect     <= redirect_n;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < `COMMIT_WIDTH; i++) begin
      commit_pc[i]   <= cmt_entry[i].pc;
      commit_dest[i] <= cmt_entry[i].dest;
    end
    if (redirect_n) begin
      redirect_pc <= target_n;
    end
  end

  // buffer and dispatch restart on the same pulse
  assign flush = redirect;

endmodule

// ==== hdl/dispatch_stage.sv ====
/* four-phase receiver; one req/ack handshake allocates one slot pair. valid slots must
   be packed from slot 0, and a pair pending during flush is acked but not allocated */
`timescale 1ns/1ps
`include "rob_config.svh"

module dispatch_stage
  import rob_pkg::*;
(
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    flush,
  // front end handshake
  input  logic                                    disp_req,
  input  logic [`DISPATCH_WIDTH-1:0]              disp_valid,
  input  logic [`DISPATCH_WIDTH-1:0][`PC_W-1:0]   disp_pc,
  input  instr_type_e [`DISPATCH_WIDTH-1:0]       disp_type,
  input  logic [`DISPATCH_WIDTH-1:0][`AREG_W-1:0] disp_dest,
  output logic                                    disp_ack,
  output rob_idx_t [`DISPATCH_WIDTH-1:0]          disp_rob_idx,
  // allocation request into the buffer
  output logic                                    alloc_fire,
  output logic [`DISPATCH_WIDTH-1:0]              alloc_valid,
  output logic [`DISPATCH_WIDTH-1:0][`PC_W-1:0]   alloc_pc,
  output instr_type_e [`DISPATCH_WIDTH-1:0]       alloc_type,
  output logic [`DISPATCH_WIDTH-1:0][`AREG_W-1:0] alloc_dest,
  input  logic                                    alloc_ready,
  input  rob_idx_t [`DISPATCH_WIDTH-1:0]          alloc_idx
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_ALLOC,
    S_ACK,
    S_WAIT_LOW
  } disp_state_e;

  disp_state_e                    state_q;
  disp_state_e                    state_n;
  rob_idx_t [`DISPATCH_WIDTH-1:0] idx_q;

  // slot fields are held stable by the front end while req is high
  assign alloc_valid = disp_valid;
  assign alloc_pc    = disp_pc;
  assign alloc_type  = disp_type;
  assign alloc_dest  = disp_dest;

  // only while ack is still low, so each handshake allocates once
  assign alloc_fire = disp_req & alloc_ready & ~flush &
                      ((state_q == S_IDLE) | (state_q == S_ALLOC));

  assign disp_ack     = (state_q == S_ACK) | (state_q == S_WAIT_LOW);
  assign disp_rob_idx = idx_q;

  always_comb begin
    state_n = state_q;
    case (state_q)
      S_IDLE, S_ALLOC: begin
        if (!disp_req) begin
          state_n = S_IDLE;
        end else if (flush) begin
          // pair is younger than the redirect, drop it
          state_n = S_WAIT_LOW;
        end else if (alloc_ready) begin
          state_n = S_ACK;
        end else begin
          state_n = S_ALLOC;
        end
      end
      S_ACK:      state_n = disp_req ? S_WAIT_LOW : S_IDLE;
      S_WAIT_LOW: state_n = disp_req ? S_WAIT_LOW : S_IDLE;
      default:    state_n = S_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_n;
    end
  end

  // indices are returned for the whole ack phase
  always_ff @(posedge clk) begin
    if (alloc_fire) begin
      idx_q <= alloc_idx;
    end
  end

endmodule

// ==== hdl/reorder_buffer.sv ====
/* 8-entry circular reorder buffer with two-wide masked commit; a store result is
   accepted only at the head, and flush clears the pointers, not the entries */
`timescale 1ns/1ps
`include "rob_config.svh"

module reorder_buffer
  import rob_pkg::*;
(
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    flush,
  // allocation
  input  logic                                    alloc_fire,
  input  logic [`DISPATCH_WIDTH-1:0]              alloc_valid,
  input  logic [`DISPATCH_WIDTH-1:0][`PC_W-1:0]   alloc_pc,
  input  instr_type_e [`DISPATCH_WIDTH-1:0]       alloc_type,
  input  logic [`DISPATCH_WIDTH-1:0][`AREG_W-1:0] alloc_dest,
  output logic                                    alloc_ready,
  output rob_idx_t [`DISPATCH_WIDTH-1:0]          alloc_idx,
  // writeback
  input  logic                                    alu_valid,
  input  alu_wb_t                                 alu_data,
  output logic                                    alu_accept,
  input  logic                                    mem_valid,
  input  mem_wb_t                                 mem_data,
  output logic                                    mem_accept,
  // commit
  output logic [`COMMIT_WIDTH-1:0]                cmt_valid,
  output rob_entry_t [`COMMIT_WIDTH-1:0]          cmt_entry
);

  rob_entry_t                   rob_q [`ROB_DEPTH];
  rob_ptr_t                     head_q;
  rob_ptr_t                     tail_q;
  rob_ptr_t                     count_q;
  rob_ptr_t                     alloc_cnt;
  rob_ptr_t                     cmt_cnt;
  logic                         alloc_we;
  logic                         pair_ok;
  rob_idx_t [`COMMIT_WIDTH-1:0] cmt_idx;

  // ========================================================================
  // allocation
  // ========================================================================
  assign alloc_ready = count_q <= rob_ptr_t'(`ROB_DEPTH - `DISPATCH_WIDTH);
  assign alloc_we    = alloc_fire & alloc_ready & ~flush;

  // valid slots take consecutive indices from the tail
  always_comb begin
    alloc_cnt = '0;
    for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
      alloc_idx[i] = tail_q[ROB_IDX_W-1:0] + alloc_cnt[ROB_IDX_W-1:0];
      alloc_cnt    = alloc_cnt + rob_ptr_t'(alloc_valid[i]);
    end
  end

  // ========================================================================
  // writeback acceptance
  // ========================================================================
  assign alu_accept = 1'b1;
  // loads complete freely, a store waits until it is the oldest entry
  assign mem_accept = ~mem_data.store | (mem_data.rob_idx == cmt_idx[0]);

  // ========================================================================
  // commit selection
  // ========================================================================
  always_comb begin
    for (int i = 0; i < `COMMIT_WIDTH; i++) begin
      cmt_idx[i]   = head_q[ROB_IDX_W-1:0] + rob_idx_t'(i);
      cmt_entry[i] = rob_q[cmt_idx[i]];
    end
  end

  always_comb begin
    // no second retire behind a branch, a redirect or an exception
    pair_ok = ~cmt_entry[0].br_redirect & ~cmt_entry[1].br_redirect &
              ~cmt_entry[0].exc & ~cmt_entry[1].exc &
              (cmt_entry[0].itype != INSTR_BRANCH);
    // nothing retires in the flush cycle, those entries are younger
    cmt_valid[0] = (count_q != '0) & cmt_entry[0].complete & ~flush;
    cmt_valid[1] = cmt_valid[0] & (count_q > rob_ptr_t'(1)) &
                   cmt_entry[1].complete & pair_ok;
  end

  always_comb begin
    cmt_cnt = '0;
    for (int i = 0; i < `COMMIT_WIDTH; i++) begin
      cmt_cnt = cmt_cnt + rob_ptr_t'(cmt_valid[i]);
    end
  end

  // ========================================================================
  // pointers and entries
  // ========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else if (flush) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      head_q  <= head_q + cmt_cnt;
      tail_q  <= alloc_we ? tail_q + alloc_cnt : tail_q;
      count_q <= count_q + (alloc_we ? alloc_cnt : rob_ptr_t'(0)) - cmt_cnt;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
      if (alloc_we && alloc_valid[i]) begin
        rob_q[alloc_idx[i]] <= '{complete:    1'b0,
                                 pc:          alloc_pc[i],
                                 itype:       alloc_type[i],
                                 dest:        alloc_dest[i],
                                 br_redirect: 1'b0,
                                 br_target:   '0,
                                 exc:         1'b0};
      end
    end
    if (alu_valid && alu_accept) begin
      rob_q[alu_data.rob_idx].complete    <= 1'b1;
      rob_q[alu_data.rob_idx].br_redirect <= alu_data.redirect;
      rob_q[alu_data.rob_idx].br_target   <= alu_data.target;
    end
    if (mem_valid && mem_accept) begin
      rob_q[mem_data.rob_idx].complete <= 1'b1;
      rob_q[mem_data.rob_idx].exc      <= mem_data.exc;
    end
  end

endmodule

// ==== hdl/rob_pkg.sv ====
/* shared types of the retirement back end; writeback payloads are packed
   structs so that one generic hold stage can carry either of them */
`include "rob_config.svh"

package rob_pkg;

  // index into the buffer, plus one wrap bit for head and tail
  localparam int ROB_IDX_W = $clog2(`ROB_DEPTH);
  localparam int ROB_PTR_W = ROB_IDX_W + 1;

  typedef logic [ROB_IDX_W-1:0] rob_idx_t;
  typedef logic [ROB_PTR_W-1:0] rob_ptr_t;

  typedef enum logic [1:0] {
    INSTR_ALU    = 2'd0,
    INSTR_BRANCH = 2'd1,
    INSTR_LOAD   = 2'd2,
    INSTR_STORE  = 2'd3
  } instr_type_e;

  // one reorder buffer slot
  typedef struct packed {
    logic               complete;
    logic [`PC_W-1:0]   pc;
    instr_type_e        itype;
    logic [`AREG_W-1:0] dest;
    logic               br_redirect;
    logic [`PC_W-1:0]   br_target;
    logic               exc;
  } rob_entry_t;

  // alu result, carries the resolved branch
  typedef struct packed {
    rob_idx_t         rob_idx;
    logic             redirect;
    logic [`PC_W-1:0] target;
  } alu_wb_t;

  // memory result, stores must wait for the head
  typedef struct packed {
    rob_idx_t rob_idx;
    logic     store;
    logic     exc;
  } mem_wb_t;

endpackage

// ==== hdl/rob_top.sv ====
/* retirement back end top; dispatch uses a four-phase req/ack handshake and the
   two result ports use valid/ready, with store results held until oldest */
`timescale 1ns/1ps
`include "rob_config.svh"

module rob_top
  import rob_pkg::*;
(
  input  logic                                    clk,
  input  logic                                    rst_n,
  // dispatch
  input  logic                                    disp_req,
  input  logic [`DISPATCH_WIDTH-1:0]              disp_valid,
  input  logic [`DISPATCH_WIDTH-1:0][`PC_W-1:0]   disp_pc,
  input  instr_type_e [`DISPATCH_WIDTH-1:0]       disp_type,
  input  logic [`DISPATCH_WIDTH-1:0][`AREG_W-1:0] disp_dest,
  output logic                                    disp_ack,
  output rob_idx_t [`DISPATCH_WIDTH-1:0]          disp_rob_idx,
  // alu result
  input  logic                                    alu_wb_valid,
  input  rob_idx_t                                alu_wb_idx,
  input  logic                                    alu_wb_redirect,
  input  logic [`PC_W-1:0]                        alu_wb_target,
  output logic                                    alu_wb_ready,
  // memory result
  input  logic                                    mem_wb_valid,
  input  rob_idx_t                                mem_wb_idx,
  input  logic                                    mem_wb_store,
  input  logic                                    mem_wb_exc,
  output logic                                    mem_wb_ready,
  // commit
  output logic [`COMMIT_WIDTH-1:0]                commit_valid,
  output logic [`COMMIT_WIDTH-1:0][`PC_W-1:0]     commit_pc,
  output logic [`COMMIT_WIDTH-1:0][`AREG_W-1:0]   commit_dest,
  output logic                                    redirect,
  output logic [`PC_W-1:0]                        redirect_pc,
  output logic                                    flush
);

  logic                                    alloc_fire;
  logic [`DISPATCH_WIDTH-1:0]              alloc_valid;
  logic [`DISPATCH_WIDTH-1:0][`PC_W-1:0]   alloc_pc;
  instr_type_e [`DISPATCH_WIDTH-1:0]       alloc_type;
  logic [`DISPATCH_WIDTH-1:0][`AREG_W-1:0] alloc_dest;
  logic                                    alloc_ready;
  rob_idx_t [`DISPATCH_WIDTH-1:0]          alloc_idx;
  alu_wb_t                                 alu_in;
  alu_wb_t                                 alu_held;
  logic                                    alu_held_valid;
  logic                                    alu_accept;
  mem_wb_t                                 mem_in;
  mem_wb_t                                 mem_held;
  logic                                    mem_held_valid;
  logic                                    mem_accept;
  logic [`COMMIT_WIDTH-1:0]                cmt_valid;
  rob_entry_t [`COMMIT_WIDTH-1:0]          cmt_entry;

  assign alu_in = '{rob_idx: alu_wb_idx, redirect: alu_wb_redirect, target: alu_wb_target};
  assign mem_in = '{rob_idx: mem_wb_idx, store: mem_wb_store, exc: mem_wb_exc};

  dispatch_stage dispatch_stage_inst (
    .clk, .rst_n, .flush,
    .disp_req, .disp_valid, .disp_pc, .disp_type, .disp_dest,
    .disp_ack, .disp_rob_idx,
    .alloc_fire, .alloc_valid, .alloc_pc, .alloc_type, .alloc_dest,
    .alloc_ready, .alloc_idx
  );

  wb_hold_stage #(.payload_t(alu_wb_t)) alu_hold_inst (
    .clk, .rst_n, .flush,
    .in_valid  (alu_wb_valid),
    .in_data   (alu_in),
    .in_ready  (alu_wb_ready),
    .out_valid (alu_held_valid),
    .out_data  (alu_held),
    .accept    (alu_accept)
  );

  wb_hold_stage #(.payload_t(mem_wb_t)) mem_hold_inst (
    .clk, .rst_n, .flush,
    .in_valid  (mem_wb_valid),
    .in_data   (mem_in),
    .in_ready  (mem_wb_ready),
    .out_valid (mem_held_valid),
    .out_data  (mem_held),
    .accept    (mem_accept)
  );

  reorder_buffer reorder_buffer_inst (
    .clk, .rst_n, .flush,
    .alloc_fire, .alloc_valid, .alloc_pc, .alloc_type, .alloc_dest,
    .alloc_ready, .alloc_idx,
    .alu_valid  (alu_held_valid),
    .alu_data   (alu_held),
    .alu_accept (alu_accept),
    .mem_valid  (mem_held_valid),
    .mem_data   (mem_held),
    .mem_accept (mem_accept),
    .cmt_valid, .cmt_entry
  );

  commit_stage commit_stage_inst (
    .clk, .rst_n,
    .cmt_valid, .cmt_entry,
    .commit_valid, .commit_pc, .commit_dest,
    .redirect, .redirect_pc, .flush
  );

endmodule

// ==== hdl/wb_hold_stage.sv ====
/* one-entry holding register for a result payload; upstream ready is
   slot empty, so a new item enters only the cycle after the old one leaves */
`timescale 1ns/1ps

module wb_hold_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     flush,
  // upstream result port
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     in_ready,
  // offer to the buffer
  output logic     out_valid,
  output payload_t out_data,
  input  logic     accept
);

  logic     full_q;
  payload_t data_q;

  assign in_ready  = ~full_q;
  assign out_valid = full_q;
  assign out_data  = data_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full_q <= 1'b0;
    end else if (flush) begin
      // results of flushed entries are stale
      full_q <= 1'b0;
    end else if (in_valid && in_ready) begin
      full_q <= 1'b1;
    end else if (full_q && accept) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      data_q <= in_data;
    end
  end

endmodule

// ==== include/rob_config.svh ====
/* rob sizing, datapath widths and restart vector; depth must be a power of two
   because buffer indices wrap by truncation */
`ifndef ROB_CONFIG_SVH
`define ROB_CONFIG_SVH

// buffer geometry
`define ROB_DEPTH       8
`define DISPATCH_WIDTH  2
`define COMMIT_WIDTH    2

// datapath widths
`define PC_W            32
`define AREG_W          5

// restart address when an excepting entry retires
`define EXC_VECTOR      32'h0000_0100

`endif

// ==== run_sim.sh ====
#!/bin/sh
# build and run the reorder buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_rob_top -o sim_rob

out=$(./obj_dir/sim_rob)
echo "$out"

if echo "$out" | grep -q "ALL TESTS PASSED"; then
  exit 0
else
  exit 1
fi

// ==== testbench/rob_golden.txt ====
# D/B v pc0 type0 dest0 pc1 type1 dest1 idx0 | A idx redirect target | M idx store exc
# C pc pairing(0 new cycle, 1 same cycle, 2 any) | R redirect_pc | W commits | X | J
D 3 00001000 0 01 00001004 2 02 0
D 3 00001008 0 03 0000100c 0 04 2
A 3 0 00000000
M 1 0 0
A 2 0 00000000
A 0 0 00000000
C 00001000 2
C 00001004 1
C 00001008 0
C 0000100c 1
D 3 00001010 1 00 00001014 0 05 4
A 5 0 00000000
A 4 0 00000000
C 00001010 0
C 00001014 0
D 3 00001018 0 06 0000101c 0 07 6
A 7 0 00000000
A 6 0 00000000
C 00001018 0
C 0000101c 1
D 3 00001020 0 08 00001024 0 09 0
D 3 00001028 3 00 0000102c 0 0a 2
M 2 1 0
X
A 1 0 00000000
A 0 0 00000000
A 3 0 00000000
C 00001020 0
C 00001024 1
C 00001028 0
C 0000102c 2
D 3 00001030 1 00 00001034 0 0b 4
D 3 00001038 0 0c 0000103c 0 0d 6
A 5 0 00000000
A 6 0 00000000
A 7 0 00000000
A 4 1 00002000
C 00001030 0
R 00002000
W 13
D 3 00001040 2 0e 00001044 0 0f 0
A 1 0 00000000
M 0 0 1
C 00001040 0
R 00000100
W 14
D 3 00001050 0 10 00001054 0 11 0
D 3 00001058 0 12 0000105c 0 13 2
D 3 00001060 0 14 00001064 0 15 4
D 3 00001068 0 16 0000106c 0 17 6
B 3 00001070 0 18 00001074 0 19 0
A 1 0 00000000
A 0 0 00000000
A 3 0 00000000
A 2 0 00000000
A 5 0 00000000
A 4 0 00000000
A 7 0 00000000
A 6 0 00000000
J
A 1 0 00000000
A 0 0 00000000
C 00001050 2
C 00001054 1
C 00001058 2
C 0000105c 1
C 00001060 2
C 00001064 1
C 00001068 2
C 0000106c 1
C 00001070 2
C 00001074 1
W 24

// ==== testbench/tb_rob_top.sv ====
/* drives the rob from testbench/rob_golden.txt, run from the project root;
   commit order, pairing and redirect targets are checked against that file */
`timescale 1ns/1ps
`include "rob_config.svh"

module tb_rob_top
  import rob_pkg::*;
;

  localparam int MAX_REC = 128;
  localparam time PERIOD = 40ns;

  logic                                    clk;
  logic                                    rst_n;
  logic                                    disp_req;
  logic [`DISPATCH_WIDTH-1:0]              disp_valid;
  logic [`DISPATCH_WIDTH-1:0][`PC_W-1:0]   disp_pc;
  instr_type_e [`DISPATCH_WIDTH-1:0]       disp_type;
  logic [`DISPATCH_WIDTH-1:0][`AREG_W-1:0] disp_dest;
  logic                                    disp_ack;
  rob_idx_t [`DISPATCH_WIDTH-1:0]          disp_rob_idx;
  logic                                    alu_wb_valid;
  rob_idx_t                                alu_wb_idx;
  logic                                    alu_wb_redirect;
  logic [`PC_W-1:0]                        alu_wb_target;
  logic                                    alu_wb_ready;
  logic                                    mem_wb_valid;
  rob_idx_t                                mem_wb_idx;
  logic                                    mem_wb_store;
  logic                                    mem_wb_exc;
  logic                                    mem_wb_ready;
  logic [`COMMIT_WIDTH-1:0]                commit_valid;
  logic [`COMMIT_WIDTH-1:0][`PC_W-1:0]     commit_pc;
  logic [`COMMIT_WIDTH-1:0][`AREG_W-1:0]   commit_dest;
  logic                                    redirect;
  logic [`PC_W-1:0]                        redirect_pc;
  logic                                    flush;

  // records that are replayed, commit and redirect lines go to the queues
  string       rec_cmd [MAX_REC];
  logic [31:0] rec_arg [MAX_REC][8];
  int          num_rec;
  int          num_lines;
  logic [31:0] exp_pc_q [$];
  int          exp_pair_q [$];
  logic [31:0] exp_redir_q [$];
  // destination register of each dispatched pc
  logic [`AREG_W-1:0] dest_of_pc [logic [31:0]];
  int          value_errs;
  int          other_errs;
  int          commit_cnt;
  int          cycle;
  int          last_cyc;
  integer      seed;
  logic        loaded;
  logic        bg_busy;

  rob_top rob_top_inst (.*);

  always #(PERIOD / 2) clk = ~clk;

  // ==========================================================================
  // golden file
  // ==========================================================================
  task automatic load_golden();
    int    fd;
    int    n;
    string tok;
    string line;
    logic [31:0] a0;
    logic [31:0] a1;
    fd = $fopen("testbench/rob_golden.txt", "r");
    if (fd == 0) begin
      $display("cannot open testbench/rob_golden.txt");
      other_errs++;
      return;
    end
    while ($fscanf(fd, "%s", tok) == 1) begin
      num_lines++;
      if (tok[0] == "#") begin
        n = $fgets(line, fd);
      end else if (tok == "C") begin
        n = $fscanf(fd, "%h %d", a0, a1);
        exp_pc_q.push_back(a0);
        exp_pair_q.push_back(int'(a1));
      end else if (tok == "R") begin
        n = $fscanf(fd, "%h", a0);
        exp_redir_q.push_back(a0);
      end else begin
        rec_cmd[num_rec] = tok;
        if (tok == "D" || tok == "B") begin
          n = $fscanf(fd, "%h %h %h %h %h %h %h %h", rec_arg[num_rec][0],
                      rec_arg[num_rec][1], rec_arg[num_rec][2], rec_arg[num_rec][3],
                      rec_arg[num_rec][4], rec_arg[num_rec][5], rec_arg[num_rec][6],
                      rec_arg[num_rec][7]);
          dest_of_pc[rec_arg[num_rec][1]] = rec_arg[num_rec][3][`AREG_W-1:0];
          dest_of_pc[rec_arg[num_rec][4]] = rec_arg[num_rec][6][`AREG_W-1:0];
        end else if (tok == "A" || tok == "M") begin
          n = $fscanf(fd, "%h %h %h", rec_arg[num_rec][0], rec_arg[num_rec][1],
                      rec_arg[num_rec][2]);
        end else if (tok == "W") begin
          n = $fscanf(fd, "%d", rec_arg[num_rec][0]);
        end
        num_rec++;
      end
    end
    $fclose(fd);
  endtask

  // ==========================================================================
  // drivers
  // ==========================================================================
  task automatic dispatch_pair(input int r);
    @(posedge clk);
    #2;
    disp_valid   = rec_arg[r][0][1:0];
    disp_pc[0]   = rec_arg[r][1];
    disp_type[0] = instr_type_e'(rec_arg[r][2][1:0]);
    disp_dest[0] = rec_arg[r][3][`AREG_W-1:0];
    disp_pc[1]   = rec_arg[r][4];
    disp_type[1] = instr_type_e'(rec_arg[r][5][1:0]);
    disp_dest[1] = rec_arg[r][6][`AREG_W-1:0];
    disp_req     = 1'b1;
    while (!disp_ack) begin
      @(posedge clk);
      #2;
    end
    assert (disp_rob_idx[0] == rec_arg[r][7][2:0]) else begin
      $display("Fail %0t: pair at pc %h got index %0d, expected %0d", $time,
               rec_arg[r][1], disp_rob_idx[0], rec_arg[r][7]);
      value_errs++;
    end
    // second slot takes the next index in program order
    if (rec_arg[r][0][1]) begin
      assert (disp_rob_idx[1] == rob_idx_t'(rec_arg[r][7] + 1)) else begin
        $display("Fail %0t: pair at pc %h got second index %0d, expected %0d", $time,
                 rec_arg[r][1], disp_rob_idx[1], rob_idx_t'(rec_arg[r][7] + 1));
        value_errs++;
      end
    end
    disp_req = 1'b0;
    while (disp_ack) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic write_alu(input int r);
    @(posedge clk);
    #2;
    alu_wb_valid    = 1'b1;
    alu_wb_idx      = rec_arg[r][0][2:0];
    alu_wb_redirect = rec_arg[r][1][0];
    alu_wb_target   = rec_arg[r][2];
    // ready only moves on an edge, so this value holds until the next one
    while (!alu_wb_ready) begin
      @(posedge clk);
      #2;
    end
    @(posedge clk);
    #2;
    alu_wb_valid = 1'b0;
    // the slot is full for the cycle after capture
    assert (!alu_wb_ready) else begin
      $display("Fail %0t: alu result slot reports ready while holding an item", $time);
      value_errs++;
    end
  endtask

  task automatic write_mem(input int r);
    @(posedge clk);
    #2;
    mem_wb_valid = 1'b1;
    mem_wb_idx   = rec_arg[r][0][2:0];
    mem_wb_store = rec_arg[r][1][0];
    mem_wb_exc   = rec_arg[r][2][0];
    while (!mem_wb_ready) begin
      @(posedge clk);
      #2;
    end
    @(posedge clk);
    #2;
    mem_wb_valid = 1'b0;
  endtask

  task automatic random_gap();
    int gap;
    gap = int'($unsigned($random(seed)) % 4);
    repeat (gap) begin
      @(posedge clk);
      #2;
    end
  endtask

  // ==========================================================================
  // commit and redirect monitor, sampled mid-cycle
  // ==========================================================================
  always @(negedge clk) begin
    cycle++;
    for (int i = 0; i < `COMMIT_WIDTH; i++) begin
      if (rst_n && commit_valid[i]) begin
        assert (exp_pc_q.size() != 0) else begin
          $display("Fail %0t: unexpected commit of pc %h", $time, commit_pc[i]);
          value_errs++;
        end
        if (exp_pc_q.size() != 0) begin
          assert (commit_pc[i] == exp_pc_q[0]) else begin
            $display("Fail %0t: committed pc %h, expected %h", $time, commit_pc[i],
                     exp_pc_q[0]);
            value_errs++;
          end
          assert (commit_dest[i] == dest_of_pc[exp_pc_q[0]]) else begin
            $display("Fail %0t: pc %h committed dest %0d, expected %0d", $time,
                     exp_pc_q[0], commit_dest[i], dest_of_pc[exp_pc_q[0]]);
            value_errs++;
          end
          assert ((exp_pair_q[0] == 2) || ((exp_pair_q[0] == 1) == (cycle == last_cyc)))
          else begin
            $display("Fail %0t: pc %h retired in the wrong cycle for its pair", $time,
                     commit_pc[i]);
            value_errs++;
          end
          void'(exp_pc_q.pop_front());
          void'(exp_pair_q.pop_front());
        end
        last_cyc = cycle;
        commit_cnt++;
      end
    end
    // flush and redirect pulse together with the retiring commit
    if (rst_n && (redirect || flush)) begin
      assert (redirect && flush && (commit_valid != '0)) else begin
        $display("Fail %0t: flush %b and redirect %b not paired with a commit", $time,
                 flush, redirect);
        value_errs++;
      end
    end
    if (rst_n && redirect) begin
      assert (exp_redir_q.size() != 0) else begin
        $display("Fail %0t: unexpected redirect to %h", $time, redirect_pc);
        value_errs++;
      end
      if (exp_redir_q.size() != 0) begin
        assert (redirect_pc == exp_redir_q[0]) else begin
          $display("Fail %0t: redirect to %h, expected %h", $time, redirect_pc,
                   exp_redir_q[0]);
          value_errs++;
        end
        void'(exp_redir_q.pop_front());
      end
    end
  end

  // hang guard scaled by the golden length
  initial begin
    wait (loaded);
    repeat ((num_lines + 1) * 200) @(posedge clk);
    $display("timeout: the run did not finish, the DUT seems to hang");
    $display("SOME TESTS FAILED");
    $finish;
  end

  // ==========================================================================
  // main sequence
  // ==========================================================================
  initial begin
    clk             = 1'b0;
    rst_n           = 1'b0;
    disp_req        = 1'b0;
    disp_valid      = '0;
    disp_pc         = '0;
    disp_type[0]    = INSTR_ALU;
    disp_type[1]    = INSTR_ALU;
    disp_dest       = '0;
    alu_wb_valid    = 1'b0;
    alu_wb_idx      = '0;
    alu_wb_redirect = 1'b0;
    alu_wb_target   = '0;
    mem_wb_valid    = 1'b0;
    mem_wb_idx      = '0;
    mem_wb_store    = 1'b0;
    mem_wb_exc      = 1'b0;
    value_errs      = 0;
    other_errs      = 0;
    commit_cnt      = 0;
    cycle           = 0;
    last_cyc        = -10;
    seed            = 32'h7240;
    num_rec         = 0;
    num_lines       = 0;
    bg_busy         = 1'b0;
    loaded          = 1'b0;
    load_golden();
    loaded = 1'b1;
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;

    for (int r = 0; r < num_rec; r++) begin
      if (rec_cmd[r] == "D") begin
        dispatch_pair(r);
      end else if (rec_cmd[r] == "B") begin
        bg_busy = 1'b1;
        fork
          begin
            dispatch_pair(r);
            bg_busy = 1'b0;
          end
        join_none
        // buffer is full, ack must not come before a commit frees room
        repeat (10) @(posedge clk);
        #2;
        assert (!disp_ack) else begin
          $display("Fail %0t: pair acked while the buffer is full", $time);
          value_errs++;
        end
      end else if (rec_cmd[r] == "J") begin
        wait (!bg_busy);
      end else if (rec_cmd[r] == "A") begin
        write_alu(r);
        random_gap();
      end else if (rec_cmd[r] == "M") begin
        write_mem(r);
        random_gap();
      end else if (rec_cmd[r] == "X") begin
        assert (!mem_wb_ready) else begin
          $display("Fail %0t: store result not held back from the buffer", $time);
          value_errs++;
        end
      end else if (rec_cmd[r] == "W") begin
        while (commit_cnt < int'(rec_arg[r][0])) @(posedge clk);
        // let the flush pulse pass
        repeat (3) @(posedge clk);
      end
    end

    repeat (20) @(posedge clk);
    assert (exp_pc_q.size() == 0 && exp_redir_q.size() == 0) else begin
      $display("expected commits or redirects never appeared: %0d pcs, %0d redirects",
               exp_pc_q.size(), exp_redir_q.size());
      other_errs++;
    end
    $display("errors: %0d wrong values, %0d other failures", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
